/* design/riscv_pkg.sv */
package riscv_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // Word address widths, 4 KiB each
  localparam int imem_awidth = 10;
  localparam int dmem_awidth = 10;

  localparam logic [11:0] csr_tohost = 12'h51e;

  // RV32I opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // Load and store widths
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  // ALU function codes
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101; // srl or sra by bit 30
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // Branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [2:0] f3_csrrw  = 3'b001;
  localparam logic [2:0] f3_csrrwi = 3'b101;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_t;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_t;

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit import riscv_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   run,
  input  logic                   redirect,
  input  logic [xlen-1:0]        redirect_pc,
  input  logic                   prog_we,
  input  logic [imem_awidth-1:0] prog_addr,
  input  logic [xlen-1:0]        prog_data,
  output logic [xlen-1:0]        pc,
  output logic [xlen-1:0]        inst
);

  logic [xlen-1:0] imem [2**imem_awidth];
  logic [xlen-1:0] pc_next;

  // Run low parks the PC, otherwise redirect beats sequential
  always_comb begin
    if (!run) begin
      pc_next = reset_pc;
    end else if (redirect) begin
      pc_next = redirect_pc;
    end else begin
      pc_next = pc + xlen'(4);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

  // Load port and fetch port share the array
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
    inst <= imem[pc[imem_awidth+1:2]]; // Lags pc by one cycle
  end

  // Programs are only loaded while the core is parked
  prog_load_parked: assert property (
    @(posedge clk) disable iff (!arst_n) prog_we |-> !run
  );

endmodule

/* design/decode_unit.sv */
`timescale 1ns/1ns

module decode_unit import riscv_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic [xlen-1:0] inst,
  input  logic            wb_we,
  input  logic [4:0]      wb_rd,
  input  logic [xlen-1:0] wb_data,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data,
  output logic [xlen-1:0] imm,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [4:0]      rd,
  output alu_op_t         alu_op,
  output logic            alu_src_a,
  output logic            alu_src_b,
  output logic            branch,
  output logic            jump,
  output logic            jalr,
  output logic            mem_read,
  output logic            mem_write,
  output logic            reg_we,
  output logic            csr_write,
  output logic            csr_use_imm,
  output logic [2:0]      mem_funct3,
  output wb_sel_t         wb_sel
);

  logic [xlen-1:0] regs [1:31]; // x0 has no storage
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            writes_rd;
  logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode     = inst[6:0];
  assign funct3     = inst[14:12];
  assign rs1        = inst[19:15];
  assign rs2        = inst[24:20];
  assign rd         = inst[11:7];
  assign mem_funct3 = funct3; // Also the branch condition

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_ff @(posedge clk) begin
    if (wb_we && wb_rd != 5'd0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Write-through so the writeback in this cycle is seen
  assign rs1_data = (rs1 == 5'd0) ? '0 :
                    (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 :
                    (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic bit30,
                                         input logic is_reg);
    case (f3)
      f3_add:  return (is_reg && bit30) ? alu_sub : alu_add; // No subi
      f3_sll:  return alu_sll;
      f3_slt:  return alu_slt;
      f3_sltu: return alu_sltu;
      f3_xor:  return alu_xor;
      f3_sr:   return bit30 ? alu_sra : alu_srl;
      f3_or:   return alu_or;
      f3_and:  return alu_and;
      default: return alu_add;
    endcase
  endfunction

  always_comb begin
    imm         = imm_i;
    alu_op      = alu_add;
    alu_src_a   = 1'b0;
    alu_src_b   = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    jalr        = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    writes_rd   = 1'b0;
    wb_sel      = wb_alu;
    csr_write   = 1'b0;
    csr_use_imm = 1'b0;
    case (opcode)
      op_lui: begin
        imm       = imm_u;
        alu_op    = alu_pass_b;
        alu_src_b = 1'b1;
        writes_rd = 1'b1;
      end
      op_auipc: begin
        imm       = imm_u;
        alu_src_a = 1'b1; // pc + imm
        alu_src_b = 1'b1;
        writes_rd = 1'b1;
      end
      op_jal: begin
        imm       = imm_j;
        jump      = 1'b1;
        writes_rd = 1'b1;
        wb_sel    = wb_pc4;
      end
      op_jalr: begin
        alu_src_b = 1'b1;
        jump      = 1'b1;
        jalr      = 1'b1;
        writes_rd = 1'b1;
        wb_sel    = wb_pc4;
      end
      op_branch: begin
        imm    = imm_b;
        branch = 1'b1;
      end
      op_load: begin
        alu_src_b = 1'b1;
        mem_read  = 1'b1;
        writes_rd = 1'b1;
        wb_sel    = wb_mem;
      end
      op_store: begin
        imm       = imm_s;
        alu_src_b = 1'b1;
        mem_write = 1'b1;
      end
      op_imm: begin
        alu_op    = alu_decode(funct3, inst[30], 1'b0);
        alu_src_b = 1'b1;
        writes_rd = 1'b1;
      end
      op_reg: begin
        alu_op    = alu_decode(funct3, inst[30], 1'b1);
        writes_rd = 1'b1;
      end
      op_system: begin
        // Only tohost exists, write-only
        csr_write   = (funct3 == f3_csrrw || funct3 == f3_csrrwi) &&
                      inst[31:20] == csr_tohost;
        csr_use_imm = funct3 == f3_csrrwi;
      end
      default: ;
    endcase
  end

  assign reg_we = writes_rd && rd != 5'd0;

  // Writes to x0 are dropped before writeback
  wb_rd_nonzero: assert property (
    @(posedge clk) disable iff (!arst_n) wb_we |-> wb_rd != 5'd0
  );

endmodule

/* design/execute_unit.sv */
`timescale 1ns/1ns

module execute_unit import riscv_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            valid,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] imm,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  input  alu_op_t         alu_op,
  input  logic            alu_src_a,
  input  logic            alu_src_b,
  input  logic            branch,
  input  logic            jump,
  input  logic            jalr,
  input  logic [2:0]      funct3,
  input  logic            csr_write,
  input  logic            csr_use_imm,
  input  logic            wb_we,
  input  logic [4:0]      wb_rd,
  input  logic [xlen-1:0] wb_data,
  output logic [xlen-1:0] alu_result,
  output logic [xlen-1:0] store_data,
  output logic            redirect,
  output logic [xlen-1:0] redirect_pc,
  output logic [xlen-1:0] csr,
  output logic            csr_wr
);

  logic [xlen-1:0] fwd_a, fwd_b;
  logic [xlen-1:0] op_a, op_b;
  logic            cond;

  // Bypass from the writeback register
  assign fwd_a = (wb_we && wb_rd != 5'd0 && wb_rd == rs1) ? wb_data : rs1_data;
  assign fwd_b = (wb_we && wb_rd != 5'd0 && wb_rd == rs2) ? wb_data : rs2_data;

  assign op_a       = alu_src_a ? pc : fwd_a;
  assign op_b       = alu_src_b ? imm : fwd_b;
  assign store_data = fwd_b;

  always_comb begin
    case (alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << op_b[4:0];
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_xor:    alu_result = op_a ^ op_b;
      alu_srl:    alu_result = op_a >> op_b[4:0];
      alu_sra:    alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
      alu_or:     alu_result = op_a | op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b; // LUI
      default:    alu_result = '0;
    endcase
  end

  always_comb begin
    case (funct3)
      f3_beq:  cond = fwd_a == fwd_b;
      f3_bne:  cond = fwd_a != fwd_b;
      f3_blt:  cond = $signed(fwd_a) < $signed(fwd_b);
      f3_bge:  cond = $signed(fwd_a) >= $signed(fwd_b);
      f3_bltu: cond = fwd_a < fwd_b;
      f3_bgeu: cond = fwd_a >= fwd_b;
      default: cond = 1'b0;
    endcase
  end

  assign redirect    = valid && (jump || (branch && cond));
  assign redirect_pc = jalr ? {alu_result[xlen-1:1], 1'b0} : pc + imm;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csr    <= '0;
      csr_wr <= 1'b0;
    end else begin
      csr_wr <= valid && csr_write;
      if (valid && csr_write) begin
        csr <= csr_use_imm ? {{(xlen-5){1'b0}}, rs1} : fwd_a; // rs1 field is zimm
      end
    end
  end

  // The flush must kill the slot behind a taken transfer
  redirect_flushes: assert property (
    @(posedge clk) disable iff (!arst_n) redirect |=> !valid
  );

endmodule

/* design/data_mem.sv */
`timescale 1ns/1ns

module data_mem import riscv_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            read,
  input  logic            write,
  input  logic [2:0]      funct3,
  input  logic [xlen-1:0] addr,
  input  logic [xlen-1:0] wdata,
  output logic [xlen-1:0] rdata
);

  logic [xlen-1:0]        dmem [2**dmem_awidth];
  logic [dmem_awidth-1:0] word_addr;
  logic [3:0]             wbe;
  logic [xlen-1:0]        wdata_lane;
  logic [xlen-1:0]        rword;
  logic                   read_q;
  logic [2:0]             funct3_q;
  logic [1:0]             offs_q;
  logic [7:0]             rbyte;
  logic [15:0]            rhalf;
  logic [xlen-1:0]        ext;

  assign word_addr  = addr[dmem_awidth+1:2];
  assign wdata_lane = wdata << {addr[1:0], 3'b000};

  // Byte enables from width and offset
  always_comb begin
    case (funct3[1:0])
      f3_b[1:0]: wbe = 4'b0001 << addr[1:0];
      f3_h[1:0]: wbe = 4'b0011 << addr[1:0];
      default:   wbe = 4'b1111;
    endcase
    if (!write) begin
      wbe = 4'b0000;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wbe[i]) begin
        dmem[word_addr][8*i +: 8] <= wdata_lane[8*i +: 8];
      end
    end
    rword    <= dmem[word_addr];
    funct3_q <= funct3;   // Travels with the read
    offs_q   <= addr[1:0];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      read_q <= 1'b0;
    end else begin
      read_q <= read;
    end
  end

  assign rbyte = rword[{offs_q, 3'b000} +: 8];
  assign rhalf = rword[{offs_q[1], 4'b0000} +: 16];

  always_comb begin
    case (funct3_q)
      f3_b:    ext = {{24{rbyte[7]}}, rbyte};
      f3_bu:   ext = {24'b0, rbyte};
      f3_h:    ext = {{16{rhalf[15]}}, rhalf};
      f3_hu:   ext = {16'b0, rhalf};
      default: ext = rword;
    endcase
  end

  assign rdata = read_q ? ext : '0;

  natural_alignment: assert property (
    @(posedge clk) disable iff (!arst_n)
    (read || write) |->
      ((funct3 == f3_w) -> addr[1:0] == 2'b00) &&
      ((funct3 == f3_h || funct3 == f3_hu) -> !addr[0])
  );

endmodule

/* design/riscv_core.sv */
`timescale 1ns/1ns

module riscv_core import riscv_pkg::*; (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   run,
  input  logic                   prog_we,
  input  logic [imem_awidth-1:0] prog_addr,
  input  logic [xlen-1:0]        prog_data,
  output logic [xlen-1:0]        csr,
  output logic                   csr_wr
);

  logic [xlen-1:0] pc_f, inst_f;
  logic            redirect;
  logic [xlen-1:0] redirect_pc;

  // Decode stage
  logic            d_valid;
  logic [xlen-1:0] d_pc, d_rs1_data, d_rs2_data, d_imm;
  logic [4:0]      d_rs1, d_rs2, d_rd;
  alu_op_t         d_alu_op;
  logic            d_alu_src_a, d_alu_src_b, d_branch, d_jump, d_jalr;
  logic            d_mem_read, d_mem_write, d_reg_we, d_csr_write, d_csr_use_imm;
  logic [2:0]      d_mem_funct3;
  wb_sel_t         d_wb_sel;

  // Execute stage
  logic            e_valid;
  logic [xlen-1:0] e_pc, e_rs1_data, e_rs2_data, e_imm;
  logic [4:0]      e_rs1, e_rs2, e_rd;
  alu_op_t         e_alu_op;
  logic            e_alu_src_a, e_alu_src_b, e_branch, e_jump, e_jalr;
  logic            e_mem_read, e_mem_write, e_reg_we, e_csr_write, e_csr_use_imm;
  logic [2:0]      e_mem_funct3;
  wb_sel_t         e_wb_sel;
  logic [xlen-1:0] alu_result, store_data;

  // Writeback stage
  logic            wb_we;
  logic [4:0]      wb_rd;
  wb_sel_t         wb_src;
  logic [xlen-1:0] wb_result, wb_link, wb_data, mem_rdata;

  fetch_unit u_fetch (
    .clk, .arst_n, .run, .redirect, .redirect_pc,
    .prog_we, .prog_addr, .prog_data,
    .pc(pc_f), .inst(inst_f)
  );

  // Valid bits drop on redirect or when parked
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      d_valid <= 1'b0;
      e_valid <= 1'b0;
      wb_we   <= 1'b0;
    end else begin
      d_valid <= run && !redirect;
      e_valid <= run && d_valid && !redirect;
      wb_we   <= run && e_valid && e_reg_we;
    end
  end

  always_ff @(posedge clk) begin
    d_pc <= pc_f; // Pairs with the RAM output
  end

  decode_unit u_decode (
    .clk, .arst_n, .inst(inst_f), .wb_we, .wb_rd, .wb_data,
    .rs1_data(d_rs1_data), .rs2_data(d_rs2_data), .imm(d_imm),
    .rs1(d_rs1), .rs2(d_rs2), .rd(d_rd), .alu_op(d_alu_op),
    .alu_src_a(d_alu_src_a), .alu_src_b(d_alu_src_b),
    .branch(d_branch), .jump(d_jump), .jalr(d_jalr),
    .mem_read(d_mem_read), .mem_write(d_mem_write), .reg_we(d_reg_we),
    .csr_write(d_csr_write), .csr_use_imm(d_csr_use_imm),
    .mem_funct3(d_mem_funct3), .wb_sel(d_wb_sel)
  );

  always_ff @(posedge clk) begin
    e_pc          <= d_pc;
    e_rs1_data    <= d_rs1_data;
    e_rs2_data    <= d_rs2_data;
    e_imm         <= d_imm;
    e_rs1         <= d_rs1;
    e_rs2         <= d_rs2;
    e_rd          <= d_rd;
    e_alu_op      <= d_alu_op;
    e_alu_src_a   <= d_alu_src_a;
    e_alu_src_b   <= d_alu_src_b;
    e_branch      <= d_branch;
    e_jump        <= d_jump;
    e_jalr        <= d_jalr;
    e_mem_read    <= d_mem_read;
    e_mem_write   <= d_mem_write;
    e_reg_we      <= d_reg_we;
    e_csr_write   <= d_csr_write;
    e_csr_use_imm <= d_csr_use_imm;
    e_mem_funct3  <= d_mem_funct3;
    e_wb_sel      <= d_wb_sel;
  end

  execute_unit u_execute (
    .clk, .arst_n, .valid(e_valid), .pc(e_pc),
    .rs1_data(e_rs1_data), .rs2_data(e_rs2_data), .imm(e_imm),
    .rs1(e_rs1), .rs2(e_rs2), .alu_op(e_alu_op),
    .alu_src_a(e_alu_src_a), .alu_src_b(e_alu_src_b),
    .branch(e_branch), .jump(e_jump), .jalr(e_jalr), .funct3(e_mem_funct3),
    .csr_write(e_csr_write), .csr_use_imm(e_csr_use_imm),
    .wb_we, .wb_rd, .wb_data, .alu_result, .store_data,
    .redirect, .redirect_pc, .csr, .csr_wr
  );

  data_mem u_dmem (
    .clk, .arst_n,
    .read(e_valid && e_mem_read), .write(e_valid && e_mem_write),
    .funct3(e_mem_funct3), .addr(alu_result), .wdata(store_data),
    .rdata(mem_rdata) // Already extended
  );

  always_ff @(posedge clk) begin
    wb_rd     <= e_rd;
    wb_src    <= e_wb_sel;
    wb_result <= alu_result;
    wb_link   <= e_pc + xlen'(4);
  end

  always_comb begin
    case (wb_src)
      wb_mem:  wb_data = mem_rdata;
      wb_pc4:  wb_data = wb_link;
      default: wb_data = wb_result;
    endcase
  end

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen (
  output logic clk
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

/* tb/riscv_core_tb.sv */
`timescale 1ns/1ns

module riscv_core_tb import riscv_pkg::*; ();

  logic                   clk;
  logic                   arst_n;
  logic                   run;
  logic                   prog_we;
  logic [imem_awidth-1:0] prog_addr;
  logic [xlen-1:0]        prog_data;
  logic [xlen-1:0]        csr;
  logic                   csr_wr;

  // Commands from the data file
  byte             cmd_q[$];
  logic [xlen-1:0] addr_q[$];
  logic [xlen-1:0] data_q[$];

  logic [xlen-1:0] expect_q[$]; // Pending tohost values
  int              errors;
  int              matched;
  int              cycles;
  int              cycle_limit;
  int              test_num;
  int              words;
  int              expected;

  clk_gen u_clk (.clk);

  riscv_core uut (
    .clk, .arst_n, .run, .prog_we, .prog_addr, .prog_data, .csr, .csr_wr
  );

  task automatic check_value(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp_val);
    if (got !== exp_val) begin
      errors++;
      $display("Error: %s is %h, expected %h", name, got, exp_val);
    end
  endtask

  task automatic read_data_file();
    int              fd;
    int              n;
    int              count;
    string           line;
    byte             c;
    logic [xlen-1:0] a;
    logic [xlen-1:0] d;
    count = 0;
    fd = $fopen("tb/program_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the program data file");
    end else begin
      while ($fgets(line, fd) > 0) begin
        c = line.getc(0);
        a = '0;
        d = '0;
        if (c == "L") begin
          n = $sscanf(line, "L %h %h", a, d);
          count++;
          if (n != 2) begin
            errors++;
            $display("Malformed load line in the program data file");
          end
        end else if (c == "E") begin
          n = $sscanf(line, "E %h", d);
          if (n != 1) begin
            errors++;
            $display("Malformed expect line in the program data file");
          end
        end else if (c == "X") begin
          cycle_limit += 20 * count + 100; // Budget of one test
          count = 0;
        end
        if (c == "L" || c == "E" || c == "R" || c == "X") begin
          cmd_q.push_back(c);
          addr_q.push_back(a);
          data_q.push_back(d);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic load_word(input logic [imem_awidth-1:0] addr,
                           input logic [xlen-1:0] data);
    prog_we   = 1'b1;
    prog_addr = addr;
    prog_data = data;
    @(negedge clk);
    prog_we   = 1'b0;
  endtask

  // Wait for the queued writes, then park the core
  task automatic end_test(input int test, input int n_words, input int n_expected);
    int waited;
    waited = 0;
    while (matched < n_expected && waited < 20 * n_words + 50) begin
      @(posedge clk);
      waited++;
    end
    repeat (16) @(posedge clk); // Stray writes from flushed slots land here
    @(negedge clk);
    run = 1'b0;
    repeat (4) @(negedge clk);
    if (matched < n_expected) begin
      errors++;
      $display("Test %0d ended after %0d of %0d expected csr writes",
               test, matched, n_expected);
    end
    expect_q.delete();
    matched = 0;
  endtask

  // One expected value per csr_wr pulse
  always @(negedge clk) begin
    if (arst_n && csr_wr !== 1'b0) begin
      if (expect_q.size() > 0) begin
        check_value("csr", csr, expect_q.pop_front());
        matched++;
      end else begin
        errors++;
        $display("Unexpected csr write of %h", csr);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the core did not finish", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    arst_n      = 1'b0;
    run         = 1'b0;
    prog_we     = 1'b0;
    prog_addr   = '0;
    prog_data   = '0;
    errors      = 0;
    matched     = 0;
    cycles      = 0;
    cycle_limit = 100; // Margin for reset
    test_num    = 0;
    words       = 0;
    expected    = 0;
    read_data_file();
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_value("csr", csr, '0);
    repeat (4) @(negedge clk); // Parked, so csr_wr must stay low
    foreach (cmd_q[i]) begin
      case (cmd_q[i])
        "L": begin
          load_word(addr_q[i][imem_awidth-1:0], data_q[i]);
          words++;
        end
        "E": begin
          expect_q.push_back(data_q[i]);
          expected++;
        end
        "R": run = 1'b1;
        "X": begin
          test_num++;
          end_test(test_num, words, expected);
          words    = 0;
          expected = 0;
        end
        default: ;
      endcase
    end
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* tb/program_input.txt */
# L <word address> <instruction>, E <tohost value>, R raises run, X ends the test
# Text after the hex fields is the assembly of the word
L 00 ffb00093 addi x1, x0, -5
L 01 00c08113 addi x2, x1, 12
L 02 0020a1b3 slt x3, x1, x2
L 03 0020b233 sltu x4, x1, x2
L 04 4010d293 srai x5, x1, 1
L 05 40110333 sub x6, x2, x1
L 06 123453b7 lui x7, 0x12345
L 07 00001417 auipc x8, 1
L 08 01c0d493 srli x9, x1, 28
L 09 00449513 slli x10, x9, 4
L 0a 007545b3 xor x11, x10, x7
L 0b 0ff5f613 andi x12, x11, 0xff
L 0c 51e61073 csrrw x0, tohost, x12
L 0d 51e19073 csrrw x0, tohost, x3
L 0e 51e21073 csrrw x0, tohost, x4
L 0f 51e29073 csrrw x0, tohost, x5
L 10 51e31073 csrrw x0, tohost, x6
L 11 51e39073 csrrw x0, tohost, x7
L 12 51e41073 csrrw x0, tohost, x8
L 13 0000006f jal x0, 0
E 000000f0
E 00000001
E 00000000
E fffffffd
E 0000000c
E 12345000
E 0000101c
R
X
L 00 10000093 addi x1, x0, 0x100
L 01 11223137 lui x2, 0x11223
L 02 34410113 addi x2, x2, 0x344
L 03 0020a023 sw x2, 0(x1)
L 04 08800193 addi x3, x0, 0x88
L 05 003080a3 sb x3, 1(x1)
L 06 aa500213 addi x4, x0, -0x55b
L 07 00409123 sh x4, 2(x1)
L 08 00108283 lb x5, 1(x1)
L 09 51e29073 csrrw x0, tohost, x5
L 0a 0010c303 lbu x6, 1(x1)
L 0b 00209383 lh x7, 2(x1)
L 0c 0020d403 lhu x8, 2(x1)
L 0d 0000a483 lw x9, 0(x1)
L 0e 00148513 addi x10, x9, 1
L 0f 51e31073 csrrw x0, tohost, x6
L 10 51e39073 csrrw x0, tohost, x7
L 11 51e41073 csrrw x0, tohost, x8
L 12 51e51073 csrrw x0, tohost, x10
L 13 0000006f jal x0, 0
E ffffff88
E 00000088
E fffffaa5
E 0000faa5
E faa58845
R
X
L 00 00300093 addi x1, x0, 3
L 01 fff00113 addi x2, x0, -1
L 02 00114663 blt x2, x1, +12
L 03 51efd073 csrrwi x0, tohost, 31
L 04 51efd073 csrrwi x0, tohost, 31
L 05 00116463 bltu x2, x1, +8
L 06 51e2d073 csrrwi x0, tohost, 5
L 07 00c001ef jal x3, +12
L 08 51efd073 csrrwi x0, tohost, 31
L 09 51efd073 csrrwi x0, tohost, 31
L 0a 51e19073 csrrw x0, tohost, x3
L 0b 04000213 addi x4, x0, 0x40
L 0c 005202e7 jalr x5, 5(x4)
L 0d 51efd073 csrrwi x0, tohost, 31
L 0e 51efd073 csrrwi x0, tohost, 31
L 0f 51efd073 csrrwi x0, tohost, 31
L 10 51efd073 csrrwi x0, tohost, 31
L 11 51e29073 csrrw x0, tohost, x5
L 12 00209663 bne x1, x2, +12
L 13 51efd073 csrrwi x0, tohost, 31
L 14 51efd073 csrrwi x0, tohost, 31
L 15 00115463 bge x2, x1, +8
L 16 51ead073 csrrwi x0, tohost, 21
L 17 00117463 bgeu x2, x1, +8
L 18 51efd073 csrrwi x0, tohost, 31
L 19 00108063 beq x1, x1, 0
E 00000005
E 00000020
E 00000034
E 00000015
R
X

/* verilog.f */
design/riscv_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/data_mem.sv
design/riscv_core.sv
tb/clk_gen.sv
tb/riscv_core_tb.sv
